//--- st_mem_pkg.sv
package st_mem_pkg;

	//////////////////////////////////////////////////
	// bus level types
	//////////////////////////////////////////////////

	// 68000 word address, byte lane bit dropped
	typedef logic [23:1] word_addr_t;

	// one bus data word
	typedef logic [15:0] data_word_t;

	// {uds, lds}
	typedef logic [1:0] byte_sel_t;

	// host download target
	typedef logic [3:0] dl_index_t;

	// 8 MHz bus slots, one clk_32 each
	typedef enum logic [1:0] {
		SLOT_PRE   = 2'd0,
		SLOT_CPU   = 2'd1,
		SLOT_VIDEO = 2'd2,
		SLOT_SPARE = 2'd3
	} bus_slot_t;

	// configured st ram size
	typedef enum logic [2:0] {
		RAM_512K = 3'd0,
		RAM_1M   = 3'd1,
		RAM_2M   = 3'd2,
		RAM_4M   = 3'd3,
		RAM_8M   = 3'd4,
		RAM_14M  = 3'd5
	} ram_size_t;

	//////////////////////////////////////////////////
	// memory map
	//////////////////////////////////////////////////

	// upload bases as word addresses (byte address >> 1)
	localparam word_addr_t TOS256_BASE = 23'h700000;  // e00000
	localparam word_addr_t TOS192_BASE = 23'h7e0000;  // fc0000
	localparam word_addr_t CART_BASE   = 23'h7d0000;  // fa0000
	localparam word_addr_t CLEAR_BASE  = 23'h000000;

	// viking frame buffer at c00000 (st layout)
	localparam logic [5:0] VIKING_WIN_ST = 6'b110000;
	// viking frame buffer at e80000 (himem layout)
	localparam logic [4:0] VIKING_WIN_HI = 5'b11101;

	// accesses seen before the driver counts as loaded
	localparam logic [7:0] VIKING_USE_COUNT = 8'd255;

endpackage

//--- rom_upload.sv
`timescale 1ns/10ps

module rom_upload (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   host_dl_i,
	input  logic                   host_wr_i,
	input  st_mem_pkg::dl_index_t  host_index_i,
	input  st_mem_pkg::data_word_t host_data_i,
	input  st_mem_pkg::bus_slot_t  slot_i,
	output logic                   dl_active_o,
	output logic                   dl_wr_o,
	output st_mem_pkg::word_addr_t dl_addr_o,
	output st_mem_pkg::data_word_t dl_data_o,
	output logic                   tos192k_o
);

	import st_mem_pkg::*;

	logic       dl_q;
	logic       wr_toggle;
	logic       wr_toggle_seen;
	word_addr_t base_addr;

	// download level, one register behind the host
	assign dl_active_o = dl_q;

	// target base per index
	always_comb begin
		case (host_index_i)
			4'd0:    base_addr = TOS256_BASE;
			4'd1:    base_addr = TOS192_BASE;
			4'd2:    base_addr = CART_BASE;
			default: base_addr = CLEAR_BASE;
		endcase
	end

	//////////////////////////////////////////////////
	// host side
	//////////////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			dl_q      <= 1'b0;
			wr_toggle <= 1'b0;
		end else begin
			dl_q <= host_dl_i;
			// each write flips the toggle, picked up in the precycle
			if (host_wr_i && host_dl_i) begin
				wr_toggle <= ~wr_toggle;
			end
		end
	end

	// address and data payload
	always_ff @(posedge clk_32) begin
		// start one word early, first write pre-increments
		if (!dl_q && host_dl_i) begin
			dl_addr_o <= base_addr - 23'd1;
		end
		if (host_wr_i && host_dl_i) begin
			dl_addr_o <= dl_addr_o + 23'd1;
			// host sends little endian byte pairs
			dl_data_o <= {host_data_i[7:0], host_data_i[15:8]};
		end
	end

	//////////////////////////////////////////////////
	// precycle side
	//////////////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			wr_toggle_seen <= 1'b0;
			dl_wr_o        <= 1'b0;
			tos192k_o      <= 1'b0;
		end else begin
			dl_wr_o <= 1'b0;
			// sampled in pre, so the strobe lands in the cpu slot
			if (slot_i == SLOT_PRE) begin
				wr_toggle_seen <= wr_toggle;
				dl_wr_o        <= wr_toggle ^ wr_toggle_seen;
			end
			// rom layout follows where the image was written
			if (dl_q) begin
				if (dl_addr_o[23:18] == 6'b111111) begin
					tos192k_o <= 1'b1;
				end else if (dl_addr_o[23:20] == 4'he) begin
					tos192k_o <= 1'b0;
				end
			end
		end
	end

	// upload writes only ever go out in the cpu slot
	a_wr_in_cpu_slot: assert property (
		@(posedge clk_32) disable iff (!xsint)
		dl_wr_o |-> (slot_i == SLOT_CPU)
	) else $error("dl_wr_o outside SLOT_CPU");

endmodule

//--- ram_window.sv
`timescale 1ns/10ps

module ram_window (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   ras_n_i,
	input  st_mem_pkg::word_addr_t ram_addr_i,
	input  st_mem_pkg::ram_size_t  ram_size_i,
	input  logic                   viking_en_i,
	input  logic                   himem_i,
	output logic                   cs_req_o
);

	import st_mem_pkg::*;

	logic ras_n_q;
	logic size_en;
	logic viking_hit;
	logic ram_en;
	logic ras_fall;

	//////////////////////////////////////////////////
	// ras edge
	//////////////////////////////////////////////////

	// ras idles high
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_q <= 1'b1;
		end else begin
			ras_n_q <= ras_n_i;
		end
	end

	assign ras_fall = ras_n_q & ~ras_n_i;

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////

	// top of configured st ram
	always_comb begin
		case (ram_size_i)
			RAM_512K: size_en = (ram_addr_i[23:19] == 5'b00000);
			RAM_1M:   size_en = (ram_addr_i[23:20] == 4'b0000);
			RAM_2M:   size_en = (ram_addr_i[23:21] == 3'b000);
			RAM_4M:   size_en = (ram_addr_i[23:22] == 2'b00);
			RAM_8M:   size_en = ~ram_addr_i[23];
			// everything below c00000
			RAM_14M:  size_en = (ram_addr_i[23:22] != 2'b11);
			default:  size_en = 1'b0;
		endcase
	end

	// frame buffer window, placement set by himem
	assign viking_hit = viking_en_i & (himem_i ?
		(ram_addr_i[23:19] == VIKING_WIN_HI) :
		(ram_addr_i[23:18] == VIKING_WIN_ST));

	assign ram_en = size_en | viking_hit;

	// address zero is never a real chipset access
	assign cs_req_o = ras_fall & (|ram_addr_i) & ram_en;

	// one ras cycle, one request
	a_req_single: assert property (
		@(posedge clk_32) disable iff (!xsint)
		cs_req_o |=> !cs_req_o
	) else $error("cs_req_o held longer than one cycle");

endmodule

//--- viking_detect.sv
`timescale 1ns/10ps

module viking_detect (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   cpu_as_n_i,
	input  st_mem_pkg::word_addr_t cpu_addr_i,
	input  logic                   viking_en_i,
	input  logic                   himem_i,
	input  st_mem_pkg::bus_slot_t  slot_i,
	output logic                   viking_active_o
);

	import st_mem_pkg::*;

	logic [7:0] use_cnt;
	logic       win_hit;
	logic       use_seen;

	// cpu pointing into the frame buffer
	assign win_hit = himem_i ?
		(cpu_addr_i[23:19] == VIKING_WIN_HI) :
		(cpu_addr_i[23:18] == VIKING_WIN_ST);

	// one count per bus cycle, taken in the precycle
	assign use_seen = (slot_i == SLOT_PRE) & ~cpu_as_n_i & viking_en_i & win_hit;

	//////////////////////////////////////////////////
	// usage counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			use_cnt         <= 8'd0;
			viking_active_o <= 1'b0;
		end else begin
			// saturate, a few probes are not enough
			if (use_seen && (use_cnt != VIKING_USE_COUNT)) begin
				use_cnt <= use_cnt + 8'd1;
			end
			viking_active_o <= (use_cnt == VIKING_USE_COUNT);
		end
	end

	// video source never falls back without a reset
	a_active_sticky: assert property (
		@(posedge clk_32) disable iff (!xsint)
		viking_active_o |=> viking_active_o
	) else $error("viking_active_o dropped");

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  st_mem_pkg::word_addr_t dl_addr_i,
	input  st_mem_pkg::data_word_t dl_data_i,
	input  logic                   cs_req_i,
	input  st_mem_pkg::word_addr_t ram_addr_i,
	input  logic                   ram_we_i,
	input  st_mem_pkg::byte_sel_t  ram_ds_i,
	input  st_mem_pkg::data_word_t ram_din_i,
	input  logic                   viking_active_i,
	input  logic                   video_rd_i,
	input  st_mem_pkg::word_addr_t video_addr_i,
	output st_mem_pkg::bus_slot_t  slot_o,
	output logic                   mem_req_o,
	output logic                   mem_we_o,
	output st_mem_pkg::word_addr_t mem_addr_o,
	output st_mem_pkg::byte_sel_t  mem_ds_o,
	output st_mem_pkg::data_word_t mem_din_o
);

	import st_mem_pkg::*;

	bus_slot_t slot_q;
	logic      upload_grant;
	logic      video_grant;

	//////////////////////////////////////////////////
	// slot counter
	//////////////////////////////////////////////////

	// pre, cpu, video, spare, wraps at 2 bits
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			slot_q <= SLOT_PRE;
		end else begin
			slot_q <= bus_slot_t'(slot_q + 2'd1);
		end
	end

	assign slot_o = slot_q;

	//////////////////////////////////////////////////
	// grant by slot owner
	//////////////////////////////////////////////////

	// cpu slot goes to the uploader for the whole download
	assign upload_grant = (slot_q == SLOT_CPU) & dl_active_i;
	// video slot only once the viking driver is running
	assign video_grant  = (slot_q == SLOT_VIDEO) & viking_active_i & video_rd_i;

	// control half of the request
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mem_req_o <= 1'b0;
			mem_we_o  <= 1'b0;
		end else if (upload_grant) begin
			mem_req_o <= dl_wr_i;
			mem_we_o  <= 1'b1;
		end else if (video_grant) begin
			mem_req_o <= 1'b1;
			mem_we_o  <= 1'b0;
		end else begin
			mem_req_o <= cs_req_i;
			mem_we_o  <= ram_we_i;
		end
	end

	// address, strobes and write data
	always_ff @(posedge clk_32) begin
		if (upload_grant) begin
			mem_addr_o <= dl_addr_i;
			mem_ds_o   <= 2'b11;
		end else if (video_grant) begin
			mem_addr_o <= video_addr_i;
			mem_ds_o   <= 2'b11;
		end else begin
			mem_addr_o <= ram_addr_i;
			mem_ds_o   <= ram_ds_i;
		end
		// write data follows the download level, not the slot
		mem_din_o <= dl_active_i ? dl_data_i : ram_din_i;
	end

	// a granted video slot is always a plain read
	a_video_is_read: assert property (
		@(posedge clk_32) disable iff (!xsint)
		video_grant |=> (mem_req_o && !mem_we_o)
	) else $error("video slot issued a write");

endmodule

//--- st_mem_top.sv
`timescale 1ns/10ps

module st_mem_top (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   host_dl_i,
	input  logic                   host_wr_i,
	input  st_mem_pkg::dl_index_t  host_index_i,
	input  st_mem_pkg::data_word_t host_data_i,
	input  st_mem_pkg::ram_size_t  ram_size_i,
	input  logic                   viking_en_i,
	input  logic                   himem_i,
	input  logic                   cpu_as_n_i,
	input  st_mem_pkg::word_addr_t cpu_addr_i,
	input  logic                   ras_n_i,
	input  st_mem_pkg::word_addr_t ram_addr_i,
	input  logic                   ram_we_i,
	input  st_mem_pkg::byte_sel_t  ram_ds_i,
	input  st_mem_pkg::data_word_t ram_din_i,
	input  st_mem_pkg::word_addr_t video_addr_i,
	input  logic                   video_rd_i,
	output logic                   mem_req_o,
	output logic                   mem_we_o,
	output st_mem_pkg::word_addr_t mem_addr_o,
	output st_mem_pkg::byte_sel_t  mem_ds_o,
	output st_mem_pkg::data_word_t mem_din_o,
	output st_mem_pkg::bus_slot_t  bus_cycle_o,
	output logic                   viking_active_o,
	output logic                   tos192k_o
);

	import st_mem_pkg::*;

	// uploader to arbiter
	logic       dl_active;
	logic       dl_wr;
	word_addr_t dl_addr;
	data_word_t dl_data;

	// chipset request
	logic       cs_req;

	//////////////////////////////////////////////////
	// peers
	//////////////////////////////////////////////////

	rom_upload u_rom_upload (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.host_dl_i    (host_dl_i),
		.host_wr_i    (host_wr_i),
		.host_index_i (host_index_i),
		.host_data_i  (host_data_i),
		.slot_i       (bus_cycle_o),
		.dl_active_o  (dl_active),
		.dl_wr_o      (dl_wr),
		.dl_addr_o    (dl_addr),
		.dl_data_o    (dl_data),
		.tos192k_o    (tos192k_o)
	);

	ram_window u_ram_window (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.ras_n_i     (ras_n_i),
		.ram_addr_i  (ram_addr_i),
		.ram_size_i  (ram_size_i),
		.viking_en_i (viking_en_i),
		.himem_i     (himem_i),
		.cs_req_o    (cs_req)
	);

	viking_detect u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cpu_as_n_i      (cpu_as_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.viking_en_i     (viking_en_i),
		.himem_i         (himem_i),
		.slot_i          (bus_cycle_o),
		.viking_active_o (viking_active_o)
	);

	//////////////////////////////////////////////////
	// sdram request port
	//////////////////////////////////////////////////

	mem_arbiter u_mem_arbiter (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.dl_active_i     (dl_active),
		.dl_wr_i         (dl_wr),
		.dl_addr_i       (dl_addr),
		.dl_data_i       (dl_data),
		.cs_req_i        (cs_req),
		.ram_addr_i      (ram_addr_i),
		.ram_we_i        (ram_we_i),
		.ram_ds_i        (ram_ds_i),
		.ram_din_i       (ram_din_i),
		.viking_active_i (viking_active_o),
		.video_rd_i      (video_rd_i),
		.video_addr_i    (video_addr_i),
		.slot_o          (bus_cycle_o),
		.mem_req_o       (mem_req_o),
		.mem_we_o        (mem_we_o),
		.mem_addr_o      (mem_addr_o),
		.mem_ds_o        (mem_ds_o),
		.mem_din_o       (mem_din_o)
	);

endmodule

//--- tb_st_mem_checks.svh
`ifndef TB_ST_MEM_CHECKS_SVH
`define TB_ST_MEM_CHECKS_SVH

//////////////////////////////////////////////////
// compare tasks, one per result type
//////////////////////////////////////////////////

task automatic check_addr(input string name, input word_addr_t got, input word_addr_t exp);
	if (got !== exp) begin
		$display("error: %0t ns %s is %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_data(input string name, input data_word_t got, input data_word_t exp);
	if (got !== exp) begin
		$display("error: %0t ns %s is %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_ds(input string name, input byte_sel_t got, input byte_sel_t exp);
	if (got !== exp) begin
		$display("error: %0t ns %s is %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_slot(input string name, input bus_slot_t got, input bus_slot_t exp);
	if (got !== exp) begin
		$display("error: %0t ns %s is %0d, expected %0d", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("error: %0t ns %s is %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

//////////////////////////////////////////////////
// expected values from the memory map
//////////////////////////////////////////////////

// upload target as a word address
function automatic word_addr_t upload_base(input dl_index_t idx);
	logic [23:0] byte_base;
	case (idx)
		4'd0:    byte_base = 24'he00000;
		4'd1:    byte_base = 24'hfc0000;
		4'd2:    byte_base = 24'hfa0000;
		default: byte_base = 24'h000000;
	endcase
	return byte_base[23:1];
endfunction

// host pairs arrive low byte first
function automatic data_word_t swapped_word(input data_word_t d);
	return {d[7:0], d[15:8]};
endfunction

// chipset request expected for this ras cycle
function automatic logic chipset_hits(input ram_size_t size, input word_addr_t addr,
		input logic ven, input logic hi);
	logic [23:0] byte_addr;
	logic [23:0] top;
	logic        in_vik;
	byte_addr = {addr, 1'b0};
	case (size)
		RAM_512K: top = 24'h080000;
		RAM_1M:   top = 24'h100000;
		RAM_2M:   top = 24'h200000;
		RAM_4M:   top = 24'h400000;
		RAM_8M:   top = 24'h800000;
		RAM_14M:  top = 24'hc00000;
		default:  top = 24'h000000;
	endcase
	// st window c00000..c3ffff, himem window e80000..efffff
	if (hi) begin
		in_vik = ven && (byte_addr >= 24'he80000) && (byte_addr < 24'hf00000);
	end else begin
		in_vik = ven && (byte_addr >= 24'hc00000) && (byte_addr < 24'hc40000);
	end
	return (addr != '0) && ((byte_addr < top) || in_vik);
endfunction

`endif

//--- tb_st_mem.sv
`timescale 1ns/10ps

module tb_st_mem;

	import st_mem_pkg::*;

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_UPLOAD = 2'd0,
		OP_RAS    = 2'd1,
		OP_PROBE  = 2'd2,
		OP_VIDEO  = 2'd3
	} op_t;

	// count repeats the operation
	// width is the random part of the address
	typedef struct packed {
		op_t        op;
		dl_index_t  index;
		logic [8:0] count;
		ram_size_t  size;
		word_addr_t base;
		logic [4:0] width;
		logic       ven;
		logic       hi;
		logic       exp_bit;
	} row_t;

	localparam int HALF_PERIOD = 20;

	logic       clk_32;
	logic       xsint;
	logic       host_dl_i;
	logic       host_wr_i;
	dl_index_t  host_index_i;
	data_word_t host_data_i;
	ram_size_t  ram_size_i;
	logic       viking_en_i;
	logic       himem_i;
	logic       cpu_as_n_i;
	word_addr_t cpu_addr_i;
	logic       ras_n_i;
	word_addr_t ram_addr_i;
	logic       ram_we_i;
	byte_sel_t  ram_ds_i;
	data_word_t ram_din_i;
	word_addr_t video_addr_i;
	logic       video_rd_i;
	logic       mem_req_o;
	logic       mem_we_o;
	word_addr_t mem_addr_o;
	byte_sel_t  mem_ds_o;
	data_word_t mem_din_o;
	bus_slot_t  bus_cycle_o;
	logic       viking_active_o;
	logic       tos192k_o;

	row_t        rows[$];
	logic [31:0] lfsr_q;
	int          wd_cycles;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	`include "tb_st_mem_checks.svh"

	st_mem_top u_dut (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.host_dl_i       (host_dl_i),
		.host_wr_i       (host_wr_i),
		.host_index_i    (host_index_i),
		.host_data_i     (host_data_i),
		.ram_size_i      (ram_size_i),
		.viking_en_i     (viking_en_i),
		.himem_i         (himem_i),
		.cpu_as_n_i      (cpu_as_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.ras_n_i         (ras_n_i),
		.ram_addr_i      (ram_addr_i),
		.ram_we_i        (ram_we_i),
		.ram_ds_i        (ram_ds_i),
		.ram_din_i       (ram_din_i),
		.video_addr_i    (video_addr_i),
		.video_rd_i      (video_rd_i),
		.mem_req_o       (mem_req_o),
		.mem_we_o        (mem_we_o),
		.mem_addr_o      (mem_addr_o),
		.mem_ds_o        (mem_ds_o),
		.mem_din_o       (mem_din_o),
		.bus_cycle_o     (bus_cycle_o),
		.viking_active_o (viking_active_o),
		.tos192k_o       (tos192k_o)
	);

	// 40 ns period
	always #HALF_PERIOD clk_32 = ~clk_32;

	//////////////////////////////////////////////////
	// random bits and bus helpers
	//////////////////////////////////////////////////

	// fibonacci lfsr on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic add_row(input op_t op, input dl_index_t idx, input logic [8:0] cnt,
			input ram_size_t size, input word_addr_t base, input logic [4:0] width,
			input logic ven, input logic hi, input logic exp_bit);
		rows.push_back(row_t'({op, idx, cnt, size, base, width, ven, hi, exp_bit}));
	endtask

	// returns at a negedge inside slot s
	task automatic wait_slot(input bus_slot_t s);
		int n;
		n = 0;
		@(negedge clk_32);
		while (bus_cycle_o !== s) begin
			if (n == 8) begin
				$display("bus slot %0d never came round", s);
				abort_run();
			end
			n++;
			@(negedge clk_32);
		end
	endtask

	// ras fall with random direction, strobes and data
	task automatic start_ras(input word_addr_t a);
		logic [31:0] v;
		take_bits(19, v);
		ras_n_i    <= 1'b0;
		ram_addr_i <= a;
		ram_we_i   <= v[18];
		ram_ds_i   <= v[17:16];
		ram_din_i  <= v[15:0];
	endtask

	task automatic check_chipset(input word_addr_t a, input logic hit, input bus_slot_t s);
		check_slot("bus_cycle_o", bus_cycle_o, s);
		check_bit("mem_req_o", mem_req_o, hit);
		if (hit) begin
			check_addr("mem_addr_o", mem_addr_o, a);
			check_bit("mem_we_o", mem_we_o, ram_we_i);
			check_ds("mem_ds_o", mem_ds_o, ram_ds_i);
			check_data("mem_din_o", mem_din_o, ram_din_i);
		end
	endtask

	//////////////////////////////////////////////////
	// operations
	//////////////////////////////////////////////////

	task automatic check_reset();
		bus_slot_t order[4];
		order = '{SLOT_PRE, SLOT_CPU, SLOT_VIDEO, SLOT_SPARE};
		@(negedge clk_32);
		check_bit("mem_req_o", mem_req_o, 1'b0);
		check_bit("mem_we_o", mem_we_o, 1'b0);
		check_bit("viking_active_o", viking_active_o, 1'b0);
		check_bit("tos192k_o", tos192k_o, 1'b0);
		check_slot("bus_cycle_o", bus_cycle_o, SLOT_PRE);
		for (int k = 1; k < 9; k++) begin
			@(negedge clk_32);
			check_slot("bus_cycle_o", bus_cycle_o, order[k % 4]);
		end
	endtask

	task automatic run_upload(input row_t r);
		logic [31:0] v;
		data_word_t  d;
		word_addr_t  a;
		int          n;
		a = upload_base(r.index);
		@(posedge clk_32);
		host_index_i <= r.index;
		host_dl_i    <= 1'b1;
		for (int k = 0; k < r.count; k++) begin
			take_bits(16, v);
			d = v[15:0];
			// host write during a cpu slot
			wait_slot(SLOT_PRE);
			@(posedge clk_32);
			host_wr_i   <= 1'b1;
			host_data_i <= d;
			@(posedge clk_32);
			host_wr_i <= 1'b0;
			n = 0;
			@(negedge clk_32);
			while (mem_req_o !== 1'b1) begin
				if (n == 16) begin
					$display("upload write %0d never reached the sdram port", k);
					abort_run();
				end
				n++;
				@(negedge clk_32);
			end
			// decided in the cpu slot and visible in video
			check_slot("bus_cycle_o", bus_cycle_o, SLOT_VIDEO);
			check_bit("mem_we_o", mem_we_o, 1'b1);
			check_addr("mem_addr_o", mem_addr_o, a);
			check_ds("mem_ds_o", mem_ds_o, 2'b11);
			check_data("mem_din_o", mem_din_o, swapped_word(d));
			// next cpu slot carries no second write
			wait_slot(SLOT_VIDEO);
			check_bit("mem_req_o", mem_req_o, 1'b0);
			a = a + 23'd1;
		end
		@(posedge clk_32);
		host_dl_i <= 1'b0;
		repeat (3) @(negedge clk_32);
		check_bit("tos192k_o", tos192k_o, r.exp_bit);
	endtask

	task automatic run_ras(input row_t r);
		logic [31:0] v;
		word_addr_t  a;
		for (int k = 0; k < r.count; k++) begin
			take_bits(r.width, v);
			a = r.base | v[22:0];
			wait_slot(SLOT_PRE);
			@(posedge clk_32);
			start_ras(a);
			// ras held low across the cpu and video slots
			@(negedge clk_32);
			@(negedge clk_32);
			check_chipset(a, chipset_hits(r.size, a, r.ven, r.hi), SLOT_VIDEO);
			@(posedge clk_32);
			ras_n_i <= 1'b1;
			// one request per ras cycle even with ras still low
			@(negedge clk_32);
			check_bit("mem_req_o", mem_req_o, 1'b0);
		end
	endtask

	task automatic run_probe(input row_t r);
		logic [31:0] v;
		for (int k = 0; k < r.count; k++) begin
			take_bits(r.width, v);
			wait_slot(SLOT_SPARE);
			@(posedge clk_32);
			cpu_as_n_i <= 1'b0;
			cpu_addr_i <= r.base | v[22:0];
			@(posedge clk_32);
			cpu_as_n_i <= 1'b1;
		end
		// active follows the count by one register
		repeat (2) @(negedge clk_32);
		check_bit("viking_active_o", viking_active_o, r.exp_bit);
	endtask

	task automatic run_video(input row_t r);
		logic [31:0] v;
		word_addr_t  a1;
		word_addr_t  a2;
		word_addr_t  va;
		for (int k = 0; k < r.count; k++) begin
			take_bits(r.width, v);
			a1 = r.base | v[22:0];
			take_bits(r.width, v);
			a2 = r.base | v[22:0];
			take_bits(23, v);
			va = v[22:0];
			wait_slot(SLOT_PRE);
			@(posedge clk_32);
			start_ras(a1);
			video_rd_i   <= 1'b1;
			video_addr_i <= va;
			@(posedge clk_32);
			ras_n_i <= 1'b1;
			@(negedge clk_32);
			// cpu slot still carries the chipset
			check_chipset(a1, chipset_hits(r.size, a1, r.ven, r.hi), SLOT_VIDEO);
			@(posedge clk_32);
			start_ras(a2);
			@(negedge clk_32);
			check_slot("bus_cycle_o", bus_cycle_o, SLOT_SPARE);
			check_bit("mem_req_o", mem_req_o, 1'b1);
			check_bit("mem_we_o", mem_we_o, 1'b0);
			check_addr("mem_addr_o", mem_addr_o, va);
			check_ds("mem_ds_o", mem_ds_o, 2'b11);
			@(posedge clk_32);
			ras_n_i    <= 1'b1;
			video_rd_i <= 1'b0;
			@(negedge clk_32);
			// spare slot carries the chipset again
			check_chipset(a2, chipset_hits(r.size, a2, r.ven, r.hi), SLOT_PRE);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	task automatic fill_table();
		// tos 256k, tos 192k, back to 256k, cartridge
		add_row(OP_UPLOAD, 4'd0, 9'd4, RAM_512K, 23'h0, 5'd0, 1'b0, 1'b0, 1'b0);
		add_row(OP_UPLOAD, 4'd1, 9'd3, RAM_512K, 23'h0, 5'd0, 1'b0, 1'b0, 1'b1);
		add_row(OP_UPLOAD, 4'd0, 9'd2, RAM_512K, 23'h0, 5'd0, 1'b0, 1'b0, 1'b0);
		add_row(OP_UPLOAD, 4'd2, 9'd2, RAM_512K, 23'h0, 5'd0, 1'b0, 1'b0, 1'b0);
		// widths reach past the size limit so both outcomes occur
		add_row(OP_RAS, 4'd0, 9'd8, RAM_512K, 23'h0, 5'd20, 1'b0, 1'b0, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd8, RAM_1M, 23'h0, 5'd21, 1'b0, 1'b0, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd8, RAM_2M, 23'h0, 5'd22, 1'b0, 1'b0, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd8, RAM_4M, 23'h0, 5'd23, 1'b0, 1'b0, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd8, RAM_8M, 23'h0, 5'd23, 1'b0, 1'b0, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd12, RAM_14M, 23'h0, 5'd23, 1'b0, 1'b0, 1'b0);
		// address zero
		add_row(OP_RAS, 4'd0, 9'd2, RAM_14M, 23'h0, 5'd0, 1'b0, 1'b0, 1'b0);
		// viking windows at c00000 and e80000 then the st window under himem
		add_row(OP_RAS, 4'd0, 9'd4, RAM_512K, 23'h600000, 5'd17, 1'b1, 1'b0, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd4, RAM_512K, 23'h740000, 5'd18, 1'b1, 1'b1, 1'b0);
		add_row(OP_RAS, 4'd0, 9'd4, RAM_512K, 23'h600000, 5'd17, 1'b1, 1'b1, 1'b0);
		// detector sees 254 probes then the 255th
		add_row(OP_PROBE, 4'd0, 9'd254, RAM_14M, 23'h600000, 5'd17, 1'b1, 1'b0, 1'b0);
		add_row(OP_PROBE, 4'd0, 9'd1, RAM_14M, 23'h600000, 5'd17, 1'b1, 1'b0, 1'b1);
		add_row(OP_VIDEO, 4'd0, 9'd6, RAM_14M, 23'h0, 5'd20, 1'b1, 1'b0, 1'b0);
	endtask

	// watchdog sized from the table
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk_32);
		$display("watchdog expired after %0d cycles, the run timed out", wd_cycles);
		abort_run();
	end

	initial begin
		int budget;
		clk_32       = 1'b0;
		xsint        = 1'b0;
		host_dl_i    = 1'b0;
		host_wr_i    = 1'b0;
		host_index_i = '0;
		host_data_i  = '0;
		ram_size_i   = RAM_512K;
		viking_en_i  = 1'b0;
		himem_i      = 1'b0;
		cpu_as_n_i   = 1'b1;
		cpu_addr_i   = '0;
		ras_n_i      = 1'b1;
		ram_addr_i   = '0;
		ram_we_i     = 1'b0;
		ram_ds_i     = '0;
		ram_din_i    = '0;
		video_addr_i = '0;
		video_rd_i   = 1'b0;
		lfsr_q       = 32'h6d134c70;
		fill_table();
		budget = 200;
		foreach (rows[i]) begin
			budget = budget + 64 * int'(rows[i].count);
		end
		wd_cycles = budget;
		repeat (2) @(posedge clk_32);
		xsint <= 1'b1;
		check_reset();
		foreach (rows[i]) begin
			@(posedge clk_32);
			ram_size_i  <= rows[i].size;
			viking_en_i <= rows[i].ven;
			himem_i     <= rows[i].hi;
			case (rows[i].op)
				OP_UPLOAD: run_upload(rows[i]);
				OP_RAS:    run_ras(rows[i]);
				OP_PROBE:  run_probe(rows[i]);
				default:   run_video(rows[i]);
			endcase
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
st_mem_pkg.sv
rom_upload.sv
ram_window.sv
viking_detect.sv
mem_arbiter.sv
st_mem_top.sv
tb_st_mem.sv
